/* dsp_types_pkg.sv */
// Sample, accumulator and MAC sequencer types shared by the halfband decimation chain
`default_nettype none

package dsp_types_pkg;

   // Width of a real sample on every strobed port
   localparam int sample_w = 18;

   // Full precision of the multiply-accumulate, one 18x18 product wide
   localparam int accum_w = 36;

   typedef logic signed [sample_w-1:0] sample_t;
   typedef logic signed [accum_w-1:0]  accum_t;

   // One sample with its valid strobe, 19 bits in total
   // The data field means something only while stb is high
   typedef struct packed {
      logic    stb;
      sample_t data;
   } strobed_sample_t;

   // Steps of the shared multiplier, one output per pass
   typedef enum logic [1:0] {
      mac_idle,
      mac_outer,
      mac_inner,
      mac_sum
   } mac_state_t;

endpackage

`default_nettype wire

/* hb_coeff_pkg.sv */
// Halfband tap values, accumulator slice and rounder widths for the decimator stage
`default_nettype none

package hb_coeff_pkg;

   // Taps are scaled so that the centre tap of one half sits at 2^16
   localparam int coeff_w = 18;
   localparam logic signed [coeff_w-1:0] coeff_a = -18'sd10690;
   localparam logic signed [coeff_w-1:0] coeff_b = 18'sd75809;

   // Left shift that puts the centre sample at weight one half
   localparam int middle_shift = 16;

   // Part of the 36-bit accumulator that is handed to the rounder
   localparam int slice_hi = 35;
   localparam int slice_lo = 11;

   // Rounder widths, the difference is the residue carried between samples
   localparam int round_in_w  = slice_hi - slice_lo + 1;
   localparam int round_out_w = 19;
   localparam int residue_w   = round_in_w - round_out_w;

endpackage

`default_nettype wire

/* round_sd.sv */
// Error-feedback rounder that narrows a strobed value and carries the lost fraction forward
`timescale 1ns/100ps
`default_nettype none

module round_sd
(
   input  wire logic                                        clk,
   input  wire logic                                        rst,
   input  wire logic signed [hb_coeff_pkg::round_in_w-1:0]  in,
   input  wire logic                                        stb_in,
   output logic signed [hb_coeff_pkg::round_out_w-1:0]      out,
   output logic                                             stb_out
);

   import hb_coeff_pkg::*;

   // Fraction dropped by the previous output, always non-negative
   logic [residue_w-1:0] residue;

   // Input plus the carried fraction
   logic signed [round_in_w-1:0] sum;

   // The residue is zero-extended so it only ever pushes the value upwards
   // The accumulator slice has headroom, so this addition cannot wrap
   assign sum = in + signed'({{round_out_w{1'b0}}, residue});

   // Control side: the residue and the strobe are cleared by reset
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         residue <= '0;
         stb_out <= 1'b0;
      end
      else
      begin
         stb_out <= stb_in;
         // The new low bits become the correction for the next value
         if (stb_in)
            residue <= sum[residue_w-1:0];
      end
   end

   // Upper bits of the corrected sum are the truncated result
   always_ff @(posedge clk)
   begin
      if (stb_in)
         out <= sum[round_in_w-1:residue_w];
   end

endmodule

`default_nettype wire

/* small_hb_dec.sv */
// Halfband decimate-by-two stage with taps A 0 B 0.5 B 0 A, one shared multiplier and bypass
`timescale 1ns/100ps
`default_nettype none

module small_hb_dec
(
   input  wire logic                             clk,
   input  wire logic                             rst,
   input  wire logic                             run,
   input  wire logic                             bypass,
   input  wire dsp_types_pkg::strobed_sample_t   in,
   output dsp_types_pkg::strobed_sample_t        out
);

   import dsp_types_pkg::*;
   import hb_coeff_pkg::*;

   // Folding adder for a symmetric tap pair
   // The sum is halved so it stays 18 bits, the taps carry the extra factor of two
   function automatic sample_t add_half(input sample_t a, input sample_t b);
      logic signed [sample_w:0] full;
      full = {a[sample_w-1], a} + {b[sample_w-1], b};
      return full[sample_w:1];
   endfunction

   // Saturate the rounder result to the 18-bit sample range
   function automatic sample_t clip(input logic signed [round_out_w-1:0] v);
      if (v[round_out_w-1] != v[round_out_w-2])
         return v[round_out_w-1] ? {1'b1, {(sample_w-1){1'b0}}} : {1'b0, {(sample_w-1){1'b1}}};
      else
         return v[sample_w-1:0];
   endfunction

   strobed_sample_t in_d1;
   logic            phase;
   logic            go;
   sample_t         dly [1:6];
   sample_t         sum_a;
   sample_t         sum_b;
   sample_t         middle;
   mac_state_t      mac_state;
   accum_t          prod;
   accum_t          accum;
   logic            round_stb;

   logic signed [round_out_w-1:0] rnd_data;
   logic                          rnd_stb;

   // Input register, the strobe is control and gets a reset
   always_ff @(posedge clk)
   begin
      if (rst)
         in_d1.stb <= 1'b0;
      else
         in_d1.stb <= in.stb;
   end

   always_ff @(posedge clk)
   begin
      in_d1.data <= in.data;
   end

   // Phase toggles per registered sample, the second sample of a pair fires go
   always_ff @(posedge clk)
   begin
      if (rst || !run)
         phase <= 1'b0;
      else if (in_d1.stb)
         phase <= ~phase;
   end

   assign go = in_d1.stb & phase;

   // Six-deep delay line, shifted once per registered sample
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 1; i <= 6; i++)
            dly[i] <= '0;
      end
      else if (in_d1.stb)
      begin
         dly[1] <= in_d1.data;
         for (int i = 2; i <= 6; i++)
            dly[i] <= dly[i-1];
      end
   end

   // On go the two folded pairs and the centre tap are captured together
   // Outer pair is newest and sixth-oldest, inner pair is second and fourth
   always_ff @(posedge clk)
   begin
      if (go)
      begin
         sum_a  <= add_half(in_d1.data, dly[6]);
         sum_b  <= add_half(dly[2], dly[4]);
         middle <= dly[3];
      end
   end

   // Sequencer for the shared multiplier
   // Outer product is formed first, inner product one cycle later, then the sum closes
   always_ff @(posedge clk)
   begin
      if (rst || !run)
      begin
         mac_state <= mac_idle;
         round_stb <= 1'b0;
      end
      else
      begin
         round_stb <= (mac_state == mac_sum);
         case (mac_state)
            mac_idle:  mac_state <= go ? mac_outer : mac_idle;
            mac_outer: mac_state <= mac_inner;
            mac_inner: mac_state <= mac_sum;
            default:   mac_state <= mac_idle;
         endcase
      end
   end

   // Registered multiply, its operands are steered by the sequencer state
   always_ff @(posedge clk)
   begin
      if (mac_state == mac_outer)
         prod <= sum_a * coeff_a;
      else if (mac_state == mac_inner)
         prod <= sum_b * coeff_b;
   end

   // Accumulator starts from the centre at weight one half plus the outer product
   // A dropped run throws away any partial result
   always_ff @(posedge clk)
   begin
      if (rst || !run)
         accum <= '0;
      else if (mac_state == mac_inner)
         accum <= (accum_t'(middle) <<< middle_shift) + prod;
      else if (mac_state == mac_sum)
         accum <= accum + prod;
   end

   round_sd round_acc
   (
      .clk     (clk),
      .rst     (rst),
      .in      (accum[slice_hi:slice_lo]),
      .stb_in  (round_stb),
      .out     (rnd_data),
      .stb_out (rnd_stb)
   );

   // Output register picks the raw registered input in bypass, else the clipped result
   always_ff @(posedge clk)
   begin
      if (bypass)
         out.data <= in_d1.data;
      else if (rnd_stb)
         out.data <= clip(rnd_data);
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         out.stb <= 1'b0;
      else if (bypass)
         out.stb <= in_d1.stb;
      else
         out.stb <= rnd_stb;
   end

endmodule

`default_nettype wire

/* hb_dec_chain.sv */
// Two cascaded halfband decimators giving a quarter-rate output, each with its own bypass
`timescale 1ns/100ps
`default_nettype none

module hb_dec_chain
(
   input  wire logic                             clk,
   input  wire logic                             rst,
   input  wire logic                             run,
   input  wire logic                             bypass_1,
   input  wire logic                             bypass_2,
   input  wire dsp_types_pkg::strobed_sample_t   in,
   output dsp_types_pkg::strobed_sample_t        out
);

   import dsp_types_pkg::*;

   // Half-rate stream between the two stages
   // Stage 1 output spacing already meets the input limit of stage 2
   strobed_sample_t mid;

   // First decimation, full input rate to half rate
   small_hb_dec stage_1
   (
      .clk    (clk),
      .rst    (rst),
      .run    (run),
      .bypass (bypass_1),
      .in     (in),
      .out    (mid)
   );

   // Second decimation, half rate to quarter rate
   small_hb_dec stage_2
   (
      .clk    (clk),
      .rst    (rst),
      .run    (run),
      .bypass (bypass_2),
      .in     (mid),
      .out    (out)
   );

endmodule

`default_nettype wire

/* hb_dec_chain_checker.sv */
// Bound assertions for one decimator stage covering reset, strobe spacing, MAC start and bypass
`timescale 1ns/100ps
`default_nettype none

module hb_dec_chain_checker
(
   input wire logic                            clk,
   input wire logic                            rst,
   input wire logic                            bypass,
   input wire logic                            go,
   input wire dsp_types_pkg::mac_state_t       mac_state,
   input wire dsp_types_pkg::strobed_sample_t  in_reg,
   input wire dsp_types_pkg::strobed_sample_t  out_q
);

   import dsp_types_pkg::*;

   // Number of failed assertions, read by the testbench at the end of the run
   int fail_count = 0;

   // A synchronous reset clears the output strobe on the next edge
   assert property (@(posedge clk) rst |=> !out_q.stb)
      else begin $error("output strobe high after reset"); fail_count++; end

   // The filtered path never produces strobes closer than the MAC sequence allows
   assert property (@(posedge clk) disable iff (rst)
      (!bypass && out_q.stb) |=> !out_q.stb [*3])
      else begin $error("filtered output strobes too close"); fail_count++; end

   // The sequencer only starts on the second sample of a pair
   assert property (@(posedge clk) disable iff (rst)
      ($past(mac_state) == mac_idle && mac_state != mac_idle) |-> $past(go))
      else begin $error("MAC left idle without go"); fail_count++; end

   // In steady bypass the output strobe is the registered input strobe one cycle later
   assert property (@(posedge clk) disable iff (rst)
      (bypass && $past(bypass)) |-> (out_q.stb == $past(in_reg.stb)))
      else begin $error("bypass strobe does not follow input"); fail_count++; end

endmodule

bind small_hb_dec hb_dec_chain_checker chk
(
   .clk       (clk),
   .rst       (rst),
   .bypass    (bypass),
   .go        (go),
   .mac_state (mac_state),
   .in_reg    (in_d1),
   .out_q     (out)
);

`default_nettype wire

/* hb_dec_chain_tb.sv */
// Directed testbench for the two-stage halfband decimator with a bit-exact reference model
`timescale 1ns/100ps
`default_nettype none

module hb_dec_chain_tb;

   import dsp_types_pkg::*;
   import hb_coeff_pkg::*;

   // Inputs per test, used to size the run limit
   localparam int total_inputs  = 16 + 16 + 200 + 48 + 31;
   localparam int test_cycles   = total_inputs * 8 + 6 * 210 + 40;
   localparam int timeout_limit = test_cycles * 3 / 2;

   logic            clk;
   logic            rst;
   logic            run;
   logic            bypass_1;
   logic            bypass_2;
   strobed_sample_t din;
   strobed_sample_t dout;

   int      errors = 0;
   int      out_count = 0;
   int      sat_hi = 0;
   int      sat_lo = 0;
   int      cycles = 0;
   sample_t expect_q [$];
   int      due_q [$];

   // Reference state per stage: delay line, pair phase and rounder residue
   sample_t    dl [2][1:6];
   logic       ph [2];
   logic [5:0] res [2];

   hb_dec_chain UUT
   (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .bypass_1 (bypass_1),
      .bypass_2 (bypass_2),
      .in       (din),
      .out      (dout)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic tick;
      @(posedge clk);
      #2;
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   // Cycles from an input strobe to the output strobe of one stage
   // A bypassed stage is two registers, a filtering stage waits for the full MAC pass
   function automatic int stage_latency(input logic byp);
      return byp ? 2 : 7;
   endfunction

   // One stage of the model, the filter runs whether or not the stage is bypassed
   task automatic model_stage(input int s, input sample_t x, input logic byp,
                              output logic v, output sample_t y);
      longint sa;
      longint sb;
      longint acc;
      longint t;
      longint r;
      y = x;
      v = byp;
      if (ph[s])
      begin
         // Folded pairs are halved with floor, then each multiplied by its tap
         sa  = (longint'(x) + longint'(dl[s][6])) >>> 1;
         sb  = (longint'(dl[s][2]) + longint'(dl[s][4])) >>> 1;
         acc = (longint'(dl[s][3]) <<< middle_shift) + sa * longint'(coeff_a)
               + sb * longint'(coeff_b);
         t = (acc >>> slice_lo) + longint'(res[s]);
         res[s] = t[5:0];
         r = t >>> residue_w;
         if (r > 131071)
            r = 131071;
         else if (r < -131072)
            r = -131072;
         if (!byp)
         begin
            v = 1'b1;
            y = sample_t'(r);
         end
      end
      for (int i = 6; i >= 2; i--)
         dl[s][i] = dl[s][i-1];
      dl[s][1] = x;
      ph[s] = ~ph[s];
   endtask

   // Drive one sample and leave gap cycles until the next one may start
   task automatic send(input sample_t x, input int gap);
      logic    v1;
      logic    v2;
      sample_t y1;
      sample_t y2;
      din.stb  = 1'b1;
      din.data = x;
      model_stage(0, x, bypass_1, v1, y1);
      if (v1)
      begin
         model_stage(1, y1, bypass_2, v2, y2);
         if (v2)
         begin
            expect_q.push_back(y2);
            due_q.push_back(cycles + stage_latency(bypass_1) + stage_latency(bypass_2));
         end
      end
      tick;
      din.stb = 1'b0;
      repeat (gap - 1) tick;
   endtask

   // Wait for every expected output, then some idle time to catch extra strobes
   task automatic drain(input string test);
      int n;
      n = 0;
      while (expect_q.size() > 0 && n < 200)
      begin
         tick;
         n++;
      end
      if (expect_q.size() > 0)
      begin
         errors++;
         $display("%s: %0d expected outputs never arrived", test, expect_q.size());
         expect_q.delete();
         due_q.delete();
      end
      repeat (10) tick;
   endtask

   // Outputs are sampled on the falling edge, half a cycle after they settle
   always @(negedge clk)
   begin
      if (!rst && dout.stb)
      begin
         out_count++;
         if (dout.data == 18'h1ffff)
            sat_hi++;
         if (dout.data == 18'h20000)
            sat_lo++;
         if (expect_q.size() == 0)
         begin
            errors++;
            $display("Unexpected output strobe at cycle %0d with nothing expected", cycles);
         end
         else
         begin
            check_value("out.data", dout.data, expect_q.pop_front());
            check_value("out.stb cycle", cycles, due_q.pop_front());
         end
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= timeout_limit)
      begin
         $display("Timeout: run did not finish within %0d cycles", timeout_limit);
         $display("tests failed");
         $finish;
      end
   end

   task automatic test_idle;
      repeat (30) tick;
   endtask

   task automatic test_full_bypass;
      int start;
      start = out_count;
      bypass_1 = 1'b1;
      bypass_2 = 1'b1;
      for (int i = 0; i < 16; i++)
         send(sample_t'($urandom), 6);
      drain("full bypass");
      check_value("full bypass output count", out_count - start, 16);
   endtask

   task automatic test_single_stage;
      int start;
      start = out_count;
      bypass_1 = 1'b0;
      bypass_2 = 1'b1;
      for (int i = 0; i < 16; i++)
         send((i == 3) ? 18'sh1ffff : 18'sh0, 6);
      drain("single stage");
      check_value("single stage output count", out_count - start, 8);
   endtask

   task automatic test_random_chain;
      int start;
      start = out_count;
      bypass_1 = 1'b0;
      bypass_2 = 1'b0;
      for (int i = 0; i < 200; i++)
         send(sample_t'($urandom), 5 + ($urandom % 4));
      drain("random chain");
      check_value("random chain output count", out_count - start, 50);
   endtask

   // Period six pattern lines every tap up with the sign that drives the sum past full scale
   task automatic test_saturation;
      int start;
      start  = out_count;
      sat_hi = 0;
      sat_lo = 0;
      bypass_1 = 1'b0;
      bypass_2 = 1'b1;
      for (int i = 0; i < 24; i++)
         send((i % 6 == 1) ? 18'sh20000 : 18'sh1ffff, 6);
      for (int i = 0; i < 24; i++)
         send((i % 6 == 1) ? 18'sh1ffff : 18'sh20000, 6);
      drain("saturation");
      check_value("saturation output count", out_count - start, 24);
      check_value("positive clip seen", sat_hi > 0, 1);
      check_value("negative clip seen", sat_lo > 0, 1);
   endtask

   task automatic test_run_clear;
      int start;
      start = out_count;
      bypass_1 = 1'b0;
      bypass_2 = 1'b0;
      for (int i = 0; i < 15; i++)
         send(sample_t'($urandom), 6);
      drain("run clear first part");
      run = 1'b0;
      repeat (3) tick;
      ph[0] = 1'b0;
      ph[1] = 1'b0;
      run = 1'b1;
      tick;
      for (int i = 0; i < 16; i++)
         send(sample_t'($urandom), 6);
      drain("run clear second part");
      check_value("run clear output count", out_count - start, 7);
   endtask

   initial
   begin
      int assert_fails;
      rst      = 1'b1;
      run      = 1'b1;
      bypass_1 = 1'b0;
      bypass_2 = 1'b0;
      din      = '0;
      void'($urandom(32'h59a1_8f0e));
      for (int s = 0; s < 2; s++)
      begin
         ph[s]  = 1'b0;
         res[s] = '0;
         for (int i = 1; i <= 6; i++)
            dl[s][i] = '0;
      end
      repeat (10) @(posedge clk);
      #2;
      rst = 1'b0;
      tick;

      test_idle;
      test_full_bypass;
      test_single_stage;
      test_random_chain;
      test_saturation;
      test_run_clear;

      assert_fails = UUT.stage_1.chk.fail_count + UUT.stage_2.chk.fail_count;
      $display("Errors: %0d value checks, %0d assertions", errors, assert_fails);
      if (errors == 0 && assert_fails == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
dsp_types_pkg.sv
hb_coeff_pkg.sv
round_sd.sv
small_hb_dec.sv
hb_dec_chain.sv
hb_dec_chain_checker.sv
hb_dec_chain_tb.sv

/* Makefile */
# Verilator build for the halfband decimation chain

VERILATOR ?= verilator
TB_TOP    ?= hb_dec_chain_tb
RTL_TOP   ?= hb_dec_chain
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= all tests passed

RTL_SRCS = dsp_types_pkg.sv hb_coeff_pkg.sv round_sd.sv small_hb_dec.sv hb_dec_chain.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TB_TOP): $(RTL_SRCS) hb_dec_chain_checker.sv hb_dec_chain_tb.sv $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(BUILD_DIR)/V$(TB_TOP)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
